// File: rtl/ce_params.svh
`ifndef CE_PARAMS_SVH
`define CE_PARAMS_SVH

// Byte address width, host and HPS side alike
`define CE_ADDR_W      32

// One transfer word
`define CE_DATA_W      64

// Address step between consecutive words
`define CE_WORD_BYTES  8

// Word count register width
`define CE_SIZE_W      16

`define CE_CSR_ADDR_W  8

// Completion buffer entries, also the cap on outstanding reads
`define CE_FIFO_DEPTH  8

`define CE_ID_VALUE    64'h0000_00CE_0001_0001

// --------------------
// Register offsets
// --------------------
`define CE_REG_ID         8'h00
`define CE_REG_HOST_BASE  8'h08
`define CE_REG_HPS_BASE   8'h10
`define CE_REG_SIZE       8'h18
`define CE_REG_CTRL       8'h20
`define CE_REG_STATUS     8'h28

`endif

// File: rtl/ce_pkg.sv
`include "ce_params.svh"

package ce_pkg;

   // Byte address into host or HPS memory
   typedef logic [`CE_ADDR_W-1:0]      addr_t;

   typedef logic [`CE_DATA_W-1:0]      data_t;

   // Word count or word index within a transfer
   typedef logic [`CE_SIZE_W-1:0]      size_t;

   typedef logic [`CE_CSR_ADDR_W-1:0]  csr_addr_t;

   // Write response, zero is OKAY
   typedef logic [1:0]                 resp_t;

   // Host read issuer
   typedef enum logic {
      RD_IDLE,
      RD_RUN
   } rd_state_e;

   // HPS writer, one word per pass through send and wait
   typedef enum logic [1:0] {
      WR_IDLE,
      WR_SEND,
      WR_WAIT
   } wr_state_e;

endpackage

// File: rtl/ce_csr.sv
`timescale 1ns/1ps
`include "ce_params.svh"

module ce_csr (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              csr_wr_valid,
   input  ce_pkg::csr_addr_t csr_wr_addr,
   input  ce_pkg::data_t     csr_wr_data,
   output logic              csr_wr_ready,
   input  logic              csr_rd_valid,
   input  ce_pkg::csr_addr_t csr_rd_addr,
   output logic              csr_rd_ready,
   output logic              csr_rd_rvalid,
   output ce_pkg::data_t     csr_rd_data,
   output logic              start,
   output ce_pkg::addr_t     host_base,
   output ce_pkg::addr_t     hps_base,
   output ce_pkg::size_t     xfer_size,
   input  logic              xfer_done,
   input  logic              wr_err
);

   import ce_pkg::*;

   // Status register bit positions
   localparam int STAT_BUSY = 0;
   localparam int STAT_DONE = 1;
   localparam int STAT_ERR  = 2;

   logic  wr_fire;
   logic  rd_fire;
   logic  busy_q;
   logic  done_q;
   logic  err_q;
   data_t status;
   data_t rd_mux;

   assign wr_fire = csr_wr_valid & csr_wr_ready;
   assign rd_fire = csr_rd_valid & csr_rd_ready;

   // Only one read response outstanding
   assign csr_rd_ready = !csr_rd_rvalid;

   // --------------------
   // Register writes
   // --------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         csr_wr_ready <= 1'b0;
         host_base    <= '0;
         hps_base     <= '0;
         xfer_size    <= '0;
         start        <= 1'b0;
      end else begin
         csr_wr_ready <= 1'b1;
         start        <= 1'b0;
         if (wr_fire) begin
            case (csr_wr_addr)
               `CE_REG_HOST_BASE: host_base <= csr_wr_data[`CE_ADDR_W-1:0];
               `CE_REG_HPS_BASE:  hps_base <= csr_wr_data[`CE_ADDR_W-1:0];
               `CE_REG_SIZE:      xfer_size <= csr_wr_data[`CE_SIZE_W-1:0];
               // Start is dropped while a transfer runs or is just launching
               `CE_REG_CTRL:      start <= csr_wr_data[0] & !busy_q & !start;
               default: ;
            endcase
         end
      end
   end

   // --------------------
   // Transfer status
   // --------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy_q <= 1'b0;
         done_q <= 1'b0;
         err_q  <= 1'b0;
      end else if (start) begin
         busy_q <= 1'b1;
         done_q <= 1'b0;
         err_q  <= 1'b0;
      end else begin
         if (xfer_done) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
         end
         // Sticky until the next start
         if (wr_err) begin
            err_q <= 1'b1;
         end
      end
   end

   always_comb begin
      status            = '0;
      status[STAT_BUSY] = busy_q;
      status[STAT_DONE] = done_q;
      status[STAT_ERR]  = err_q;
   end

   // Control reads as zero, start is self clearing
   always_comb begin
      case (csr_rd_addr)
         `CE_REG_ID:        rd_mux = `CE_ID_VALUE;
         `CE_REG_HOST_BASE: rd_mux = data_t'(host_base);
         `CE_REG_HPS_BASE:  rd_mux = data_t'(hps_base);
         `CE_REG_SIZE:      rd_mux = data_t'(xfer_size);
         `CE_REG_STATUS:    rd_mux = status;
         default:           rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         csr_rd_rvalid <= 1'b0;
      end else begin
         csr_rd_rvalid <= rd_fire;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_fire) begin
         csr_rd_data <= rd_mux;
      end
   end

   a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
      start |-> !busy_q);

endmodule

// File: rtl/ce_rd_req.sv
`timescale 1ns/1ps
`include "ce_params.svh"

module ce_rd_req (
   input  logic          clk,
   input  logic          rst_n,
   input  logic          start,
   input  ce_pkg::addr_t host_base,
   input  ce_pkg::size_t xfer_size,
   output logic          req_valid,
   output ce_pkg::addr_t req_addr,
   input  logic          req_ready,
   input  logic          fifo_pop
);

   import ce_pkg::*;

   localparam int CRED_W = $clog2(`CE_FIFO_DEPTH) + 1;

   rd_state_e         state_q;
   addr_t             base_q;
   size_t             size_q;
   size_t             idx_q;
   logic [CRED_W-1:0] credit_q;
   logic              credit_ok;
   logic              req_fire;

   // Every issued read owns a FIFO slot until its word is popped
   assign credit_ok = credit_q < CRED_W'(`CE_FIFO_DEPTH);
   assign req_valid = (state_q == RD_RUN) && credit_ok;
   assign req_fire  = req_valid & req_ready;
   assign req_addr  = base_q + addr_t'(idx_q) * addr_t'(`CE_WORD_BYTES);

   // --------------------
   // Issue FSM
   // --------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q <= RD_IDLE;
         idx_q   <= '0;
      end else begin
         case (state_q)
            RD_IDLE: begin
               if (start && xfer_size != '0) begin
                  idx_q   <= '0;
                  state_q <= RD_RUN;
               end
            end
            RD_RUN: begin
               if (req_fire) begin
                  idx_q <= idx_q + size_t'(1);
                  if (idx_q + size_t'(1) == size_q) begin
                     state_q <= RD_IDLE;
                  end
               end
            end
            default: state_q <= RD_IDLE;
         endcase
      end
   end

   // Transfer parameters latched at start
   always_ff @(posedge clk) begin
      if (state_q == RD_IDLE && start) begin
         base_q <= host_base;
         size_q <= xfer_size;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         credit_q <= '0;
      end else begin
         case ({req_fire, fifo_pop})
            2'b10:   credit_q <= credit_q + CRED_W'(1);
            2'b01:   credit_q <= credit_q - CRED_W'(1);
            default: ;
         endcase
      end
   end

   a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
      credit_q <= CRED_W'(`CE_FIFO_DEPTH));

   a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      req_valid && !req_ready |=> req_valid && $stable(req_addr));

endmodule

// File: rtl/ce_cpl_fifo.sv
`timescale 1ns/1ps
`include "ce_params.svh"

module ce_cpl_fifo #(
   parameter int DEPTH = `CE_FIFO_DEPTH
) (
   input  logic          clk,
   input  logic          rst_n,
   input  logic          cpl_valid,
   input  ce_pkg::data_t cpl_data,
   output logic          cpl_ready,
   output logic          fifo_valid,
   output ce_pkg::data_t fifo_data,
   input  logic          fifo_pop
);

   import ce_pkg::*;

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = PTR_W + 1;

   data_t            mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             push;
   logic             pop;

   assign cpl_ready  = count_q != CNT_W'(DEPTH);
   assign fifo_valid = count_q != '0;
   // Head word straight from the array
   assign fifo_data  = mem[rd_ptr_q];

   assign push = cpl_valid & cpl_ready;
   assign pop  = fifo_pop & fifo_valid;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr_q] <= cpl_data;
      end
   end

   // Pointers wrap naturally for a power of two depth
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= wr_ptr_q + PTR_W'(1);
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + PTR_W'(1);
         end
         case ({push, pop})
            2'b10:   count_q <= count_q + CNT_W'(1);
            2'b01:   count_q <= count_q - CNT_W'(1);
            default: ;
         endcase
      end
   end

   a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
      fifo_pop |-> fifo_valid);

   // Read credits keep the host from offering a word with no room for it
   a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
      !cpl_ready |-> !cpl_valid);

endmodule

// File: rtl/ce_hps_wr.sv
`timescale 1ns/1ps
`include "ce_params.svh"

module ce_hps_wr (
   input  logic          clk,
   input  logic          rst_n,
   input  logic          start,
   input  ce_pkg::addr_t hps_base,
   input  ce_pkg::size_t xfer_size,
   input  logic          fifo_valid,
   input  ce_pkg::data_t fifo_data,
   output logic          fifo_pop,
   output logic          aw_valid,
   output ce_pkg::addr_t aw_addr,
   input  logic          aw_ready,
   output logic          w_valid,
   output ce_pkg::data_t w_data,
   input  logic          w_ready,
   input  logic          b_valid,
   input  ce_pkg::resp_t b_resp,
   output logic          b_ready,
   output logic          wr_err,
   output logic          xfer_done
);

   import ce_pkg::*;

   wr_state_e state_q;
   addr_t     base_q;
   size_t     size_q;
   size_t     idx_q;
   size_t     idx_nxt;
   logic      aw_pend_q;
   logic      w_pend_q;
   logic      aw_left;
   logic      w_left;
   logic      b_fire;
   logic      last_word;

   assign aw_valid = aw_pend_q;
   assign w_valid  = w_pend_q;
   assign aw_addr  = base_q + addr_t'(idx_q) * addr_t'(`CE_WORD_BYTES);
   // FIFO head stays put until the data beat is accepted
   assign w_data   = fifo_data;
   assign fifo_pop = w_valid & w_ready;
   assign b_ready  = (state_q == WR_WAIT);

   assign aw_left   = aw_pend_q & !aw_ready;
   assign w_left    = w_pend_q & !w_ready;
   assign b_fire    = b_valid & b_ready;
   assign idx_nxt   = idx_q + size_t'(1);
   assign last_word = (idx_nxt == size_q);

   // --------------------
   // Write FSM
   // --------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q   <= WR_IDLE;
         size_q    <= '0;
         idx_q     <= '0;
         aw_pend_q <= 1'b0;
         w_pend_q  <= 1'b0;
         wr_err    <= 1'b0;
         xfer_done <= 1'b0;
      end else begin
         wr_err    <= 1'b0;
         xfer_done <= 1'b0;
         case (state_q)
            WR_IDLE: begin
               if (start) begin
                  idx_q     <= '0;
                  size_q    <= xfer_size;
                  // Empty transfer finishes at once
                  xfer_done <= (xfer_size == '0);
               end else if (idx_q != size_q && fifo_valid) begin
                  aw_pend_q <= 1'b1;
                  w_pend_q  <= 1'b1;
                  state_q   <= WR_SEND;
               end
            end
            WR_SEND: begin
               // Address and data channels complete independently
               aw_pend_q <= aw_left;
               w_pend_q  <= w_left;
               if (!aw_left && !w_left) begin
                  state_q <= WR_WAIT;
               end
            end
            WR_WAIT: begin
               if (b_fire) begin
                  wr_err    <= (b_resp != '0);
                  idx_q     <= idx_nxt;
                  xfer_done <= last_word;
                  state_q   <= WR_IDLE;
               end
            end
            default: state_q <= WR_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == WR_IDLE && start) begin
         base_q <= hps_base;
      end
   end

   a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
      aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr));

endmodule

// File: rtl/ce_top.sv
`timescale 1ns/1ps

module ce_top (
   input  logic              clk,
   input  logic              rst_n,

   // Register port
   input  logic              csr_wr_valid,
   input  ce_pkg::csr_addr_t csr_wr_addr,
   input  ce_pkg::data_t     csr_wr_data,
   output logic              csr_wr_ready,
   input  logic              csr_rd_valid,
   input  ce_pkg::csr_addr_t csr_rd_addr,
   output logic              csr_rd_ready,
   output logic              csr_rd_rvalid,
   output ce_pkg::data_t     csr_rd_data,

   // Host memory reads
   output logic              req_valid,
   output ce_pkg::addr_t     req_addr,
   input  logic              req_ready,
   input  logic              cpl_valid,
   input  ce_pkg::data_t     cpl_data,
   output logic              cpl_ready,

   // HPS memory writes
   output logic              aw_valid,
   output ce_pkg::addr_t     aw_addr,
   input  logic              aw_ready,
   output logic              w_valid,
   output ce_pkg::data_t     w_data,
   input  logic              w_ready,
   input  logic              b_valid,
   input  ce_pkg::resp_t     b_resp,
   output logic              b_ready
);

   import ce_pkg::*;

   logic  start;
   addr_t host_base;
   addr_t hps_base;
   size_t xfer_size;
   logic  xfer_done;
   logic  wr_err;
   logic  fifo_valid;
   data_t fifo_data;
   logic  fifo_pop;

   // --------------------
   // Register decode
   // --------------------
   ce_csr u_csr (
      .clk           (clk),
      .rst_n         (rst_n),
      .csr_wr_valid  (csr_wr_valid),
      .csr_wr_addr   (csr_wr_addr),
      .csr_wr_data   (csr_wr_data),
      .csr_wr_ready  (csr_wr_ready),
      .csr_rd_valid  (csr_rd_valid),
      .csr_rd_addr   (csr_rd_addr),
      .csr_rd_ready  (csr_rd_ready),
      .csr_rd_rvalid (csr_rd_rvalid),
      .csr_rd_data   (csr_rd_data),
      .start         (start),
      .host_base     (host_base),
      .hps_base      (hps_base),
      .xfer_size     (xfer_size),
      .xfer_done     (xfer_done),
      .wr_err        (wr_err)
   );

   // --------------------
   // Host side
   // --------------------
   ce_rd_req u_rd_req (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (start),
      .host_base (host_base),
      .xfer_size (xfer_size),
      .req_valid (req_valid),
      .req_addr  (req_addr),
      .req_ready (req_ready),
      .fifo_pop  (fifo_pop)
   );

   ce_cpl_fifo u_cpl_fifo (
      .clk        (clk),
      .rst_n      (rst_n),
      .cpl_valid  (cpl_valid),
      .cpl_data   (cpl_data),
      .cpl_ready  (cpl_ready),
      .fifo_valid (fifo_valid),
      .fifo_data  (fifo_data),
      .fifo_pop   (fifo_pop)
   );

   // --------------------
   // HPS side
   // --------------------
   ce_hps_wr u_hps_wr (
      .clk        (clk),
      .rst_n      (rst_n),
      .start      (start),
      .hps_base   (hps_base),
      .xfer_size  (xfer_size),
      .fifo_valid (fifo_valid),
      .fifo_data  (fifo_data),
      .fifo_pop   (fifo_pop),
      .aw_valid   (aw_valid),
      .aw_addr    (aw_addr),
      .aw_ready   (aw_ready),
      .w_valid    (w_valid),
      .w_data     (w_data),
      .w_ready    (w_ready),
      .b_valid    (b_valid),
      .b_resp     (b_resp),
      .b_ready    (b_ready),
      .wr_err     (wr_err),
      .xfer_done  (xfer_done)
   );

endmodule

// File: tests/tb_ce_top.sv
`timescale 1ns/1ps
`include "ce_params.svh"

module tb_ce_top;

   localparam int NROWS = 5;

   typedef struct packed {
      logic [31:0] host;
      logic [31:0] hps;
      logic [15:0] size;
      int          err_idx;
      bit          stall;
      bit          busy_start;
   } row_t;

   // Host base, HPS base, words, error word (-1 none), stalls, start while busy
   row_t rows [NROWS] = '{
      '{32'h0001_0000, 32'h8000_0000, 16'd4,  -1, 1'b0, 1'b0},
      '{32'h1234_5000, 32'h8001_0000, 16'd16, -1, 1'b1, 1'b0},
      '{32'h0002_0100, 32'h8002_0000, 16'd24, -1, 1'b1, 1'b1},
      '{32'h0003_0000, 32'h8003_0000, 16'd10,  3, 1'b1, 1'b0},
      '{32'h0004_0000, 32'h8004_0000, 16'd12, -1, 1'b0, 1'b0}
   };

   logic        clk;
   logic        rst_n;
   logic        csr_wr_valid;
   logic [7:0]  csr_wr_addr;
   logic [63:0] csr_wr_data;
   logic        csr_wr_ready;
   logic        csr_rd_valid;
   logic [7:0]  csr_rd_addr;
   logic        csr_rd_ready;
   logic        csr_rd_rvalid;
   logic [63:0] csr_rd_data;
   logic        req_valid;
   logic [31:0] req_addr;
   logic        req_ready;
   logic        cpl_valid;
   logic [63:0] cpl_data;
   logic        cpl_ready;
   logic        aw_valid;
   logic [31:0] aw_addr;
   logic        aw_ready;
   logic        w_valid;
   logic [63:0] w_data;
   logic        w_ready;
   logic        b_valid;
   logic [1:0]  b_resp;
   logic        b_ready;

   logic [31:0] lfsr = 32'hf908;
   int          errors = 0;
   int          cycles = 0;
   int          cycle_limit;
   bit          cur_stall = 1'b0;
   int          cur_err = -1;
   int          n_req = 0;
   int          n_w = 0;
   int          b_cnt = 0;
   int          cpl_delay = -1;
   bit          aw_got = 1'b0;
   bit          w_got = 1'b0;
   logic [31:0] pend_q [$];
   logic [31:0] got_addr [$];
   logic [63:0] got_data [$];

   ce_top DUT (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic next_rand_bit();
      logic fb;
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   // Host memory contents
   function automatic logic [63:0] host_word(input logic [31:0] addr);
      return {~addr, addr};
   endfunction

   function automatic int total_words();
      int sum;
      sum = 0;
      for (int k = 0; k < NROWS; k++) begin
         sum += int'(rows[k].size);
      end
      return sum;
   endfunction

   task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %0t %s: got %h expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   // --------------------
   // Register port
   // --------------------
   task automatic csr_write(input logic [7:0] addr, input logic [63:0] data);
      logic fired;
      @(posedge clk);
      #1;
      csr_wr_valid = 1'b1;
      csr_wr_addr  = addr;
      csr_wr_data  = data;
      fired = 1'b0;
      while (!fired) begin
         @(negedge clk);
         fired = csr_wr_ready;
         @(posedge clk);
         #1;
      end
      csr_wr_valid = 1'b0;
   endtask

   task automatic csr_read(input logic [7:0] addr, output logic [63:0] data);
      logic fired;
      @(posedge clk);
      #1;
      csr_rd_valid = 1'b1;
      csr_rd_addr  = addr;
      fired = 1'b0;
      while (!fired) begin
         @(negedge clk);
         fired = csr_rd_ready;
         @(posedge clk);
         #1;
      end
      csr_rd_valid = 1'b0;
      // Response lands one cycle after the handshake
      @(negedge clk);
      check_eq("read response valid", 64'(csr_rd_rvalid), 64'd1);
      data = csr_rd_data;
   endtask

   // --------------------
   // Host and HPS models
   // --------------------
   initial begin
      logic req_fire;
      logic cpl_fire;
      logic aw_fire;
      logic w_fire;
      logic b_fire;
      wait (rst_n === 1'b1);
      forever begin
         // Handshakes sampled mid-cycle, where everything has settled
         @(negedge clk);
         req_fire = req_valid & req_ready;
         cpl_fire = cpl_valid & cpl_ready;
         aw_fire  = aw_valid & aw_ready;
         w_fire   = w_valid & w_ready;
         b_fire   = b_valid & b_ready;
         if (req_fire) begin
            pend_q.push_back(req_addr);
            n_req++;
         end
         if (cpl_fire) begin
            void'(pend_q.pop_front());
         end
         if (aw_fire) begin
            got_addr.push_back(aw_addr);
            aw_got = 1'b1;
         end
         if (w_fire) begin
            got_data.push_back(w_data);
            w_got = 1'b1;
            n_w++;
         end
         if (b_fire) begin
            b_cnt++;
         end
         check_eq("reads in flight within 8", 64'(n_req - n_w <= 8), 64'd1);

         @(posedge clk);
         #1;
         req_ready = cur_stall ? (next_rand_bit() | next_rand_bit()) : 1'b1;
         aw_ready  = cur_stall ? (next_rand_bit() | next_rand_bit()) : 1'b1;
         w_ready   = cur_stall ? (next_rand_bit() | next_rand_bit()) : 1'b1;

         // Completions in request order, 0 to 3 cycles late
         if (cpl_fire) begin
            cpl_valid = 1'b0;
         end
         if (!cpl_valid && pend_q.size() > 0) begin
            if (cpl_delay < 0) begin
               cpl_delay = cur_stall ? 2 * int'(next_rand_bit()) + int'(next_rand_bit()) : 0;
            end
            if (cpl_delay == 0) begin
               cpl_valid = 1'b1;
               cpl_data  = host_word(pend_q[0]);
               cpl_delay = -1;
            end else begin
               cpl_delay--;
            end
         end

         // One response per address and data pair
         if (b_fire) begin
            b_valid = 1'b0;
         end
         if (!b_valid && aw_got && w_got && (!cur_stall || next_rand_bit())) begin
            b_valid = 1'b1;
            b_resp  = (b_cnt == cur_err) ? 2'd2 : 2'd0;
            aw_got  = 1'b0;
            w_got   = 1'b0;
         end
      end
   end

   initial begin
      cycle_limit = total_words() * 40 + 2000;
      while (cycles < cycle_limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: transfers did not complete within %0d cycles", cycle_limit);
      $display("RESULT: FAIL");
      $finish;
   end

   // --------------------
   // Transfer table
   // --------------------
   initial begin
      logic [63:0] rd;
      logic [63:0] exp_data;
      logic [31:0] exp_addr;
      int          errs_at_start;
      int          passed;
      rst_n        = 1'b0;
      csr_wr_valid = 1'b0;
      csr_wr_addr  = '0;
      csr_wr_data  = '0;
      csr_rd_valid = 1'b0;
      csr_rd_addr  = '0;
      req_ready    = 1'b0;
      cpl_valid    = 1'b0;
      cpl_data     = '0;
      aw_ready     = 1'b0;
      w_ready      = 1'b0;
      b_valid      = 1'b0;
      b_resp       = '0;
      passed       = 0;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;

      for (int r = 0; r < NROWS; r++) begin
         @(posedge clk);
         #2;
         errs_at_start = errors;
         cur_stall = rows[r].stall;
         cur_err   = rows[r].err_idx;
         n_req     = 0;
         n_w       = 0;
         b_cnt     = 0;
         got_addr.delete();
         got_data.delete();

         if (r == 0) begin
            csr_read(`CE_REG_ID, rd);
            check_eq("ID register", rd, `CE_ID_VALUE);
            csr_read(8'h30, rd);
            check_eq("unmapped offset", rd, 64'd0);
         end

         csr_write(`CE_REG_HOST_BASE, 64'(rows[r].host));
         csr_write(`CE_REG_HPS_BASE, 64'(rows[r].hps));
         csr_write(`CE_REG_SIZE, 64'(rows[r].size));
         csr_read(`CE_REG_HOST_BASE, rd);
         check_eq("host base readback", rd, 64'(rows[r].host));
         csr_read(`CE_REG_HPS_BASE, rd);
         check_eq("HPS base readback", rd, 64'(rows[r].hps));
         csr_read(`CE_REG_SIZE, rd);
         check_eq("size readback", rd, 64'(rows[r].size));

         csr_write(`CE_REG_CTRL, 64'd1);
         repeat (2) @(posedge clk);
         csr_read(`CE_REG_STATUS, rd);
         check_eq("busy after start", 64'(rd[0]), 64'd1);
         check_eq("error cleared at start", 64'(rd[2]), 64'd0);

         // Reprogram and restart mid-transfer, none of it may take effect
         if (rows[r].busy_start) begin
            csr_write(`CE_REG_HOST_BASE, 64'(rows[r].host + 32'h1000));
            csr_write(`CE_REG_HPS_BASE, 64'(rows[r].hps + 32'h1000));
            csr_write(`CE_REG_SIZE, 64'd2);
            csr_write(`CE_REG_CTRL, 64'd1);
         end

         rd = '0;
         while (!rd[1]) begin
            csr_read(`CE_REG_STATUS, rd);
         end
         check_eq("busy after done", 64'(rd[0]), 64'd0);
         check_eq("error bit", 64'(rd[2]), 64'(rows[r].err_idx >= 0));
         check_eq("read request count", 64'(n_req), 64'(rows[r].size));
         check_eq("HPS address count", 64'(got_addr.size()), 64'(rows[r].size));
         check_eq("HPS data count", 64'(got_data.size()), 64'(rows[r].size));
         for (int i = 0; i < got_addr.size() && i < got_data.size(); i++) begin
            exp_addr = rows[r].hps + 32'(i) * 32'd8;
            exp_data = host_word(rows[r].host + 32'(i) * 32'd8);
            check_eq("HPS address", 64'(got_addr[i]), 64'(exp_addr));
            check_eq("HPS data", got_data[i], exp_data);
         end

         if (errors == errs_at_start) begin
            passed++;
         end
         $display("Test %0d: %0d words, stalls %0d, %s", r, rows[r].size, rows[r].stall,
                  (errors == errs_at_start) ? "ok" : "mismatch");
      end

      $display("%0d tests, %0d passed, %0d failed, %0d check errors",
               NROWS, passed, NROWS - passed, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: copy_engine.f
+incdir+rtl
rtl/ce_pkg.sv
rtl/ce_csr.sv
rtl/ce_rd_req.sv
rtl/ce_cpl_fifo.sv
rtl/ce_hps_wr.sv
rtl/ce_top.sv
tests/tb_ce_top.sv

// File: Makefile
# Verilator build and run for the copy engine testbench

VERILATOR ?= verilator
TOP       ?= tb_ce_top
FILELIST  ?= copy_engine.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= RESULT: PASS

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) rtl/ce_params.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
